//--- filelist.f
rtl/mem_pkg.sv
rtl/mem_issue_stage.sv
rtl/dcache_model.sv
rtl/load_align_stage.sv
rtl/wb_commit.sv
rtl/mem_pipe_top.sv
test/mem_pipe_tb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module mem_pipe_tb -Mdir obj_dir -o mem_pipe_tb

run: compile
	@out=$$(./obj_dir/mem_pipe_tb); echo "$$out"; \
		echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- test/mem_pipe_tb.sv
`timescale 1ns/1ns

module mem_pipe_tb;
    localparam int TIMEOUT = 40;
    localparam int N_RANDOM = 400;

    typedef struct packed {
        mem_pkg::mem_op_e  op;
        logic [31:0]       pc;
        logic [4:0]        waddr;
        logic              we;
        logic              ale;
        logic [31:0]       wdata;
        logic              fwd_seen;
    } exp_rec_t;

    logic               clk;
    logic               rst;
    logic               flush_i;
    logic               req_valid_i;
    mem_pkg::mem_req_t  req_i;
    logic               req_ready_o;
    mem_pkg::fwd_t      fwd_o;
    mem_pkg::wb_t       wb_o;
    logic               llbit_o;

    integer      seed;
    logic [7:0]  ref_mem [0:4*mem_pkg::MEM_WORDS-1];
    exp_rec_t    exp_q [$];
    logic        exp_ll;
    int          n_sent;
    int          n_retired;
    int          n_loads;
    logic        saw_backpressure;
    logic        saw_ll;

    mem_pipe_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .fwd_o       (fwd_o),
        .wb_o        (wb_o),
        .llbit_o     (llbit_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // expected retire record from the access rules and the reference memory.
    function automatic exp_rec_t predict(input mem_pkg::mem_req_t r);
        exp_rec_t    e;
        logic [9:0]  a;
        logic [9:0]  base;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        logic        is_load;
        logic        half;
        logic        word;
        a = r.addr[9:0];
        base = {a[9:2], 2'b00};
        b = ref_mem[a];
        h = {ref_mem[a + 10'd1], ref_mem[a]};
        w = {ref_mem[base + 10'd3], ref_mem[base + 10'd2], ref_mem[base + 10'd1], ref_mem[base]};
        is_load = r.op inside {mem_pkg::LD_B, mem_pkg::LD_H, mem_pkg::LD_W,
                               mem_pkg::LD_BU, mem_pkg::LD_HU, mem_pkg::LL_W};
        half = r.op inside {mem_pkg::LD_H, mem_pkg::LD_HU, mem_pkg::ST_H};
        word = r.op inside {mem_pkg::LD_W, mem_pkg::LL_W, mem_pkg::ST_W};
        e.op = r.op;
        e.pc = r.pc;
        e.waddr = r.waddr;
        e.ale = (half && a[0]) || (word && a[1:0] != 2'b00);
        e.we = is_load && !e.ale;
        e.fwd_seen = 1'b0;
        case (r.op)
            mem_pkg::LD_B:  e.wdata = {{24{b[7]}}, b};
            mem_pkg::LD_BU: e.wdata = {24'd0, b};
            mem_pkg::LD_H:  e.wdata = {{16{h[15]}}, h};
            mem_pkg::LD_HU: e.wdata = {16'd0, h};
            default:        e.wdata = w;
        endcase
        return e;
    endfunction

    task automatic apply_store(input mem_pkg::mem_req_t r);
        logic [9:0] a;
        a = r.addr[9:0];
        case (r.op)
            mem_pkg::ST_B: ref_mem[a] = r.wdata[7:0];
            mem_pkg::ST_H: begin
                ref_mem[a] = r.wdata[7:0];
                ref_mem[a + 10'd1] = r.wdata[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[a + 10'(i)] = r.wdata[8*i +: 8];
                end
            end
        endcase
    endtask

    // checks run mid-cycle, where DUT outputs and driven inputs are settled.
    always @(negedge clk) begin : monitor
        exp_rec_t e;
        exp_rec_t f;
        if (!rst) begin
            if (wb_o.valid) begin
                assert (exp_q.size() > 0)
                    else fail_run("A result retired with no request pending.");
                e = exp_q.pop_front();
                assert (wb_o.pc == e.pc)
                    else fail_run($sformatf("Mismatch wb_o.pc: got %h, expected %h", wb_o.pc, e.pc));
                assert (wb_o.waddr == e.waddr)
                    else fail_run($sformatf("Mismatch wb_o.waddr: got %h, expected %h",
                                            wb_o.waddr, e.waddr));
                assert (wb_o.we == e.we)
                    else fail_run($sformatf("Mismatch wb_o.we: got %h, expected %h", wb_o.we, e.we));
                assert (wb_o.ale == e.ale)
                    else fail_run($sformatf("Mismatch wb_o.ale: got %h, expected %h",
                                            wb_o.ale, e.ale));
                if (e.we) begin
                    assert (wb_o.wdata == e.wdata)
                        else fail_run($sformatf("Mismatch wb_o.wdata: got %h, expected %h",
                                                wb_o.wdata, e.wdata));
                    assert (e.fwd_seen)
                        else fail_run("A load retired without its data being forwarded.");
                    n_loads++;
                end
                n_retired++;
                if (e.op inside {mem_pkg::ST_B, mem_pkg::ST_H, mem_pkg::ST_W}) exp_ll = 1'b0;
                else if (e.op == mem_pkg::LL_W && !e.ale) exp_ll = 1'b1;
            end
            assert (llbit_o == exp_ll)
                else fail_run($sformatf("Mismatch llbit_o: got %h, expected %h", llbit_o, exp_ll));
            if (llbit_o) saw_ll = 1'b1;
            if (fwd_o.wreg && fwd_o.ready) begin
                assert (exp_q.size() > 0)
                    else fail_run("Forwarding is active with nothing pending.");
                f = exp_q.pop_back();
                assert (fwd_o.waddr == f.waddr)
                    else fail_run($sformatf("Mismatch fwd_o.waddr: got %h, expected %h",
                                            fwd_o.waddr, f.waddr));
                assert (fwd_o.wdata == f.wdata)
                    else fail_run($sformatf("Mismatch fwd_o.wdata: got %h, expected %h",
                                            fwd_o.wdata, f.wdata));
                f.fwd_seen = 1'b1;
                exp_q.push_back(f);
            end
            if (flush_i) begin
                exp_q.delete();                    // nothing in flight may retire now.
                exp_ll = 1'b0;
            end
            if (req_valid_i && req_ready_o) begin
                e = predict(req_i);
                exp_q.push_back(e);
                if (!e.ale && e.op inside {mem_pkg::ST_B, mem_pkg::ST_H, mem_pkg::ST_W}) begin
                    apply_store(req_i);
                end
            end
        end
    end

    task automatic make_req(input logic misalign, output mem_pkg::mem_req_t r);
        r.op = mem_pkg::mem_op_e'(4'($unsigned($random(seed)) % 9));
        r.addr = {24'd0, 8'($random(seed))};       // first 64 words only.
        r.wdata = $random(seed);
        r.waddr = 5'($random(seed));
        r.pc = 32'h1c00_0000 + 32'(n_sent) * 32'd4;
        n_sent++;
        if (misalign) begin
            if (r.op inside {mem_pkg::LD_B, mem_pkg::LD_BU, mem_pkg::ST_B}) r.op = mem_pkg::LD_W;
            r.addr[0] = 1'b1;
        end else if (r.op inside {mem_pkg::LD_H, mem_pkg::LD_HU, mem_pkg::ST_H}) begin
            r.addr[0] = 1'b0;
        end else if (r.op inside {mem_pkg::LD_W, mem_pkg::LL_W, mem_pkg::ST_W}) begin
            r.addr[1:0] = 2'b00;
        end
    endtask

    task automatic send_req(input mem_pkg::mem_req_t r);
        int   cycles;
        logic taken;
        cycles = 0;
        taken = 1'b0;
        req_i = r;
        req_valid_i = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready_o;
            if (!taken) saw_backpressure = 1'b1;
            @(posedge clk);
            #1;
            cycles++;
            if (!taken && cycles > TIMEOUT) fail_run("Timed out waiting for req_ready_o.");
        end
        req_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) fail_run("Timed out waiting for pending results to retire.");
        end
    endtask

    initial begin
        mem_pkg::mem_req_t r;
        seed = 32'hbf660a75;
        rst = 1'b1;
        flush_i = 1'b0;
        req_valid_i = 1'b0;
        req_i = '0;
        exp_ll = 1'b0;
        n_sent = 0;
        n_retired = 0;
        n_loads = 0;
        saw_backpressure = 1'b0;
        saw_ll = 1'b0;
        for (int i = 0; i < 4 * mem_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (req_ready_o) else fail_run("req_ready_o is low after reset.");
        assert (!u_dut.dc_req_valid && !wb_o.valid && !fwd_o.wreg && !llbit_o)
            else fail_run("An output is active after reset.");
        @(posedge clk);
        #1;
        // a misaligned follower waits behind an access that may miss.
        for (int n = 0; n < N_RANDOM; n++) begin
            make_req(($unsigned($random(seed)) % 6) == 0, r);
            send_req(r);
            if (($unsigned($random(seed)) % 3) == 0) begin
                make_req(1'b1, r);
                send_req(r);
            end
            wait_idle();
        end
        make_req(1'b0, r);
        r.op = mem_pkg::LL_W;
        r.addr[1:0] = 2'b00;
        send_req(r);
        wait_idle();
        assert (llbit_o) else fail_run("llbit_o did not rise after LL_W retired.");
        r.op = mem_pkg::ST_W;
        r.pc = r.pc + 32'd4;
        send_req(r);
        wait_idle();
        assert (!llbit_o) else fail_run("llbit_o did not fall after a store retired.");
        r.op = mem_pkg::LL_W;
        r.pc = r.pc + 32'd4;
        send_req(r);
        wait_idle();
        r.op = mem_pkg::LD_W;
        r.pc = r.pc + 32'd4;
        send_req(r);
        flush_i = 1'b1;                            // the load above must never retire.
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            #1;
        end
        assert (!llbit_o) else fail_run("llbit_o did not fall after a flush.");
        if (n_retired > 0 && n_loads > 0 && saw_backpressure && saw_ll && exp_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_run("The stimulus did not reach every check.");
        end
    end

endmodule

//--- rtl/mem_pipe_top.sv
`timescale 1ns/1ns

module mem_pipe_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  logic                req_valid_i,
    input  mem_pkg::mem_req_t   req_i,
    output logic                req_ready_o,
    output mem_pkg::fwd_t       fwd_o,
    output mem_pkg::wb_t        wb_o,
    output logic                llbit_o
);
    mem_pkg::issue_align_t       issue;
    logic                        stage_ready;
    logic                        dc_req_valid;
    mem_pkg::dc_req_t            dc_req;
    logic                        data_ok;
    logic [mem_pkg::DATA_W-1:0]  rdata;
    mem_pkg::align_wb_t          result;

    mem_issue_stage u_issue (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .stage_ready_i (stage_ready),
        .issue_o       (issue)
    );

    load_align_stage u_align (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .issue_i        (issue),
        .dc_req_valid_o (dc_req_valid),
        .dc_req_o       (dc_req),
        .data_ok_i      (data_ok),
        .rdata_i        (rdata),
        .stage_ready_o  (stage_ready),
        .fwd_o          (fwd_o),
        .result_o       (result)
    );

    dcache_model u_dcache (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (dc_req_valid),
        .req_i       (dc_req),
        .data_ok_o   (data_ok),
        .rdata_o     (rdata)
    );

    wb_commit u_commit (
        .clk      (clk),
        .rst      (rst),
        .flush_i  (flush_i),
        .result_i (result),
        .wb_o     (wb_o),
        .llbit_o  (llbit_o)
    );

endmodule

//--- rtl/wb_commit.sv
`timescale 1ns/1ns

module wb_commit (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  mem_pkg::align_wb_t  result_i,
    output mem_pkg::wb_t        wb_o,
    output logic                llbit_o
);
    logic          retire;
    logic          is_store;
    logic          wb_valid_q;
    mem_pkg::wb_t  wb_q;

    assign retire = result_i.valid & ~flush_i;       // a flushed entry never retires.
    assign is_store = result_i.op inside {mem_pkg::ST_B, mem_pkg::ST_H, mem_pkg::ST_W};

    always_ff @(posedge clk) begin
        if (rst) wb_valid_q <= 1'b0;
        else wb_valid_q <= retire;
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            wb_q.valid <= 1'b1;
            wb_q.we <= result_i.wreg & ~result_i.ale;
            wb_q.waddr <= result_i.waddr;
            wb_q.wdata <= result_i.wdata;
            wb_q.ale <= result_i.ale;
            wb_q.pc <= result_i.pc;
        end
    end

    always_comb begin
        wb_o = wb_q;
        wb_o.valid = wb_valid_q;
    end

    // any retiring store breaks the link, even one that faulted.
    always_ff @(posedge clk) begin
        if (rst) llbit_o <= 1'b0;
        else if (flush_i) llbit_o <= 1'b0;
        else if (retire && is_store) llbit_o <= 1'b0;
        else if (retire && result_i.op == mem_pkg::LL_W && !result_i.ale) llbit_o <= 1'b1;
    end

endmodule

//--- rtl/load_align_stage.sv
`timescale 1ns/1ns

module load_align_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  mem_pkg::issue_align_t       issue_i,
    output logic                        dc_req_valid_o,
    output mem_pkg::dc_req_t            dc_req_o,
    input  logic                        data_ok_i,
    input  logic [mem_pkg::DATA_W-1:0]  rdata_i,
    output logic                        stage_ready_o,
    output mem_pkg::fwd_t               fwd_o,
    output mem_pkg::align_wb_t          result_o
);
    logic                        mem_access;
    logic                        is_load;
    logic                        got_data;
    logic                        advance;
    logic                        data_already_ok_q;
    logic [mem_pkg::DATA_W-1:0]  data_delay_q;
    mem_pkg::cache_word_u        rword;
    logic [7:0]                  sel_byte;
    logic [15:0]                 sel_half;
    logic [mem_pkg::DATA_W-1:0]  load_data;
    mem_pkg::align_wb_t          result_d;
    mem_pkg::align_wb_t          result_q;
    logic                        result_valid_q;

    assign mem_access = issue_i.valid & issue_i.access_valid;
    assign is_load = issue_i.op inside {mem_pkg::LD_B, mem_pkg::LD_H, mem_pkg::LD_W,
                                        mem_pkg::LD_BU, mem_pkg::LD_HU, mem_pkg::LL_W};
    assign got_data = data_ok_i | data_already_ok_q;

    assign stage_ready_o = ~mem_access | got_data;
    assign advance = stage_ready_o;

    // the request drops once this instruction has its answer.
    assign dc_req_valid_o = mem_access & ~data_already_ok_q;
    assign dc_req_o.addr = issue_i.addr;
    assign dc_req_o.wdata = issue_i.wdata;
    assign dc_req_o.wstrb = issue_i.wstrb;
    assign dc_req_o.is_store = ~is_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_already_ok_q <= 1'b0;
            data_delay_q <= '0;
        end else if (advance || flush_i) begin
            data_already_ok_q <= 1'b0;
            data_delay_q <= '0;
        end else if (data_ok_i) begin
            data_already_ok_q <= 1'b1;
            data_delay_q <= rdata_i;
        end
    end

    assign rword.word = data_already_ok_q ? data_delay_q : rdata_i;
    assign sel_byte = rword.bytes[issue_i.addr[1:0]];
    assign sel_half = issue_i.addr[1] ? {rword.bytes[3], rword.bytes[2]}
                                      : {rword.bytes[1], rword.bytes[0]};

    always_comb begin
        case (issue_i.op)
            mem_pkg::LD_B:  load_data = {{24{sel_byte[7]}}, sel_byte};
            mem_pkg::LD_BU: load_data = {24'd0, sel_byte};
            mem_pkg::LD_H:  load_data = {{16{sel_half[15]}}, sel_half};
            mem_pkg::LD_HU: load_data = {16'd0, sel_half};
            default:        load_data = rword.word;    // word and linked loads.
        endcase
    end

    always_comb begin
        result_d.valid = issue_i.valid;
        result_d.op = issue_i.op;
        result_d.waddr = issue_i.waddr;
        result_d.wreg = issue_i.wreg;
        result_d.ale = issue_i.ale;
        result_d.pc = issue_i.pc;
        result_d.wdata = (is_load && mem_access) ? load_data : issue_i.wdata;
    end

    // a load is only final once the cache has answered.
    always_comb begin
        fwd_o.wreg = issue_i.valid & issue_i.wreg;
        fwd_o.waddr = issue_i.waddr;
        fwd_o.wdata = result_d.wdata;
        fwd_o.ready = (is_load && mem_access) ? got_data : 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) result_valid_q <= 1'b0;
        else if (flush_i) result_valid_q <= 1'b0;
        else if (advance) result_valid_q <= result_d.valid;
    end

    always_ff @(posedge clk) begin
        if (advance) result_q <= result_d;
    end

    always_comb begin
        result_o = result_q;
        result_o.valid = result_valid_q;
    end

endmodule

//--- rtl/dcache_model.sv
`timescale 1ns/1ns

module dcache_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid_i,
    input  mem_pkg::dc_req_t            req_i,
    output logic                        data_ok_o,
    output logic [mem_pkg::DATA_W-1:0]  rdata_o
);
    logic [mem_pkg::DATA_W-1:0]      mem_q [mem_pkg::MEM_WORDS];
    logic [mem_pkg::WORD_IDX_W-1:0]  idx;
    logic [mem_pkg::TAG_W-1:0]       req_tag;
    logic [mem_pkg::TAG_W-1:0]       tag_q;
    logic                            tag_valid_q;
    logic                            busy_q;
    logic [mem_pkg::CNT_W-1:0]       cnt_q;
    logic                            hit;
    logic                            miss_done;

    assign idx = req_i.addr[mem_pkg::WORD_IDX_W+1:2];
    assign req_tag = idx[mem_pkg::WORD_IDX_W-1:mem_pkg::LINE_OFF_W];

    assign hit = tag_valid_q & (tag_q == req_tag);
    assign miss_done = busy_q & (cnt_q == mem_pkg::MISS_CNT);

    // a hit answers in the cycle the request first shows up.
    assign data_ok_o = req_valid_i & (busy_q ? miss_done : hit);

    // the read sees the word before this cycle's store lands.
    assign rdata_o = data_ok_o ? mem_q[idx] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q <= '0;
            tag_valid_q <= 1'b0;
        end else if (!req_valid_i) begin
            busy_q <= 1'b0;                        // a dropped request abandons the miss.
            cnt_q <= '0;
        end else if (!busy_q) begin
            busy_q <= ~hit;
            cnt_q <= '0;
        end else if (miss_done) begin
            busy_q <= 1'b0;
            cnt_q <= '0;
            tag_q <= req_tag;
            tag_valid_q <= 1'b1;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (data_ok_o && req_i.is_store) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (req_i.wstrb[b]) mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
        end
    end

endmodule

//--- rtl/mem_issue_stage.sv
`timescale 1ns/1ns

module mem_issue_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  logic                  req_valid_i,
    input  mem_pkg::mem_req_t     req_i,
    output logic                  req_ready_o,
    input  logic                  stage_ready_i,
    output mem_pkg::issue_align_t issue_o
);
    logic                  valid_q;
    logic                  take;
    logic                  is_load;
    logic                  is_store;
    logic                  size_half;
    logic                  size_word;
    logic                  ale;
    mem_pkg::cache_word_u  lanes;
    mem_pkg::issue_align_t entry_d;
    mem_pkg::issue_align_t entry_q;

    always_comb begin
        is_load = 1'b0;
        is_store = 1'b0;
        size_half = 1'b0;
        size_word = 1'b0;
        case (req_i.op)
            mem_pkg::LD_B, mem_pkg::LD_BU: is_load = 1'b1;
            mem_pkg::LD_H, mem_pkg::LD_HU: begin
                is_load = 1'b1;
                size_half = 1'b1;
            end
            mem_pkg::LD_W, mem_pkg::LL_W: begin
                is_load = 1'b1;
                size_word = 1'b1;
            end
            mem_pkg::ST_B: is_store = 1'b1;
            mem_pkg::ST_H: begin
                is_store = 1'b1;
                size_half = 1'b1;
            end
            mem_pkg::ST_W: begin
                is_store = 1'b1;
                size_word = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign ale = (size_half & req_i.addr[0]) | (size_word & (req_i.addr[1:0] != 2'b00));

    // the store byte or half is copied into every lane it may land in.
    always_comb begin
        lanes.word = req_i.wdata;
        if (size_half) begin
            lanes.bytes[3] = req_i.wdata[15:8];
            lanes.bytes[2] = req_i.wdata[7:0];
        end else if (!size_word) begin
            for (int i = 0; i < mem_pkg::STRB_W; i++) begin
                lanes.bytes[i] = req_i.wdata[7:0];
            end
        end
    end

    always_comb begin
        entry_d.valid = 1'b1;
        entry_d.op = req_i.op;
        entry_d.addr = req_i.addr;
        entry_d.wdata = lanes.word;
        entry_d.waddr = req_i.waddr;
        entry_d.pc = req_i.pc;
        entry_d.ale = ale;
        entry_d.wreg = is_load & ~ale;
        entry_d.access_valid = (is_load | is_store) & ~ale;
        entry_d.wstrb = '0;
        if (is_store && !ale) begin
            if (size_word) entry_d.wstrb = 4'b1111;
            else if (size_half) entry_d.wstrb = req_i.addr[1] ? 4'b1100 : 4'b0011;
            else entry_d.wstrb = 4'b0001 << req_i.addr[1:0];
        end
    end

    assign take = ~valid_q | stage_ready_i;      // the register is empty or moves on.
    assign req_ready_o = ~flush_i & take;

    always_ff @(posedge clk) begin
        if (rst) valid_q <= 1'b0;
        else if (flush_i) valid_q <= 1'b0;
        else if (take) valid_q <= req_valid_i;
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) entry_q <= entry_d;
    end

    always_comb begin
        issue_o = entry_q;
        issue_o.valid = valid_q;
    end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int REG_ADDR_W = 5;
    localparam int STRB_W = DATA_W / 8;

    localparam int MEM_WORDS = 256;
    localparam int LINE_WORDS = 4;
    localparam int MISS_LAT = 3;              // cycles to data_ok on a line miss.

    localparam int WORD_IDX_W = $clog2(MEM_WORDS);
    localparam int LINE_OFF_W = $clog2(LINE_WORDS);
    localparam int TAG_W = WORD_IDX_W - LINE_OFF_W;
    localparam int CNT_W = $clog2(MISS_LAT + 1);
    localparam logic [CNT_W-1:0] MISS_CNT = CNT_W'(MISS_LAT - 1);

    // nine access kinds need a 4-bit code.
    typedef enum logic [3:0] {
        LD_B  = 4'd0,
        LD_H  = 4'd1,
        LD_W  = 4'd2,
        LD_BU = 4'd3,
        LD_HU = 4'd4,
        LL_W  = 4'd5,
        ST_B  = 4'd6,
        ST_H  = 4'd7,
        ST_W  = 4'd8
    } mem_op_e;

    // one data word, taken whole or lane by lane.
    typedef union packed {
        logic [DATA_W-1:0]           word;
        logic [STRB_W-1:0][7:0]      bytes;
    } cache_word_u;

    typedef struct packed {
        mem_op_e                op;
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      wdata;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [ADDR_W-1:0]      pc;
    } mem_req_t;

    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      wdata;        // store data already in its lanes.
        logic [STRB_W-1:0]      wstrb;
        logic [REG_ADDR_W-1:0]  waddr;
        logic                   wreg;
        logic                   access_valid;
        logic                   ale;
        logic [ADDR_W-1:0]      pc;
    } issue_align_t;

    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        logic [REG_ADDR_W-1:0]  waddr;
        logic                   wreg;
        logic [DATA_W-1:0]      wdata;
        logic                   ale;
        logic [ADDR_W-1:0]      pc;
    } align_wb_t;

    typedef struct packed {
        logic                   wreg;
        logic                   ready;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [DATA_W-1:0]      wdata;
    } fwd_t;

    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [DATA_W-1:0]      wdata;
        logic                   ale;
        logic [ADDR_W-1:0]      pc;
    } wb_t;

    typedef struct packed {
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      wdata;
        logic [STRB_W-1:0]      wstrb;
        logic                   is_store;
    } dc_req_t;

endpackage
